// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f list.f -o sim_rv_core

run: compile
	@out="$$(./obj_dir/sim_rv_core)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  word_t    imem_rdata,
  output word_t    imem_addr,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  word_t    rs1_val,
  input  word_t    rs2_val,
  output id_ex_t   id_ex
);

  word_t    pc;
  word_t    if_id_instr;
  opcode_t  opcode;
  logic [2:0] funct3;
  reg_idx_t rd;
  word_t    imm;
  ctrl_t    ctrl;

  assign imem_addr = pc;

  // PC and fetch register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= reset_pc;
      if_id_instr <= '0;
    end else if (!stall) begin
      pc          <= pc + 32'd4;
      if_id_instr <= imem_rdata;
    end
  end

  assign opcode = opcode_t'(if_id_instr[6:0]);
  assign funct3 = if_id_instr[14:12];
  assign rd     = if_id_instr[11:7];
  assign rs1    = if_id_instr[19:15];
  assign rs2    = if_id_instr[24:20];

  always_comb begin
    ctrl        = '0;
    imm         = '0;
    ctrl.funct3 = funct3;
    case (opcode)
      op_lui: begin
        imm             = {if_id_instr[31:12], 12'h000};
        ctrl.reg_write  = 1'b1;
        ctrl.result_sel = res_imm;
      end
      op_imm: begin
        imm            = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        // Bit 30 only marks srai here
        ctrl.alu_op    = alu_op_t'({if_id_instr[30] & (funct3 == 3'b101), funct3});
      end
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_t'({if_id_instr[30] & (funct3 inside {3'b000, 3'b101}),
                                    funct3});
      end
      op_load: begin
        if (funct3 inside {lb, lh, lw, lbu, lhu}) begin
          imm             = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
          ctrl.use_imm    = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.result_sel = res_load;
        end
      end
      op_store: begin
        if (funct3 inside {sb, sh, sw}) begin
          imm            = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      // Anything else leaves the bubble
      default: ctrl = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (!stall) begin
      id_ex <= '{ctrl: ctrl, rs1: rs1, rs2: rs2, rd: rd,
                 rs1_val: rs1_val, rs2_val: rs2_val, imm: imm};
    end
  end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    stall,
  input  id_ex_t  id_ex,
  input  word_t   mem_fwd,
  input  wb_t     wb,
  output ex_mem_t ex_mem
);

  fwd_sel_t sel1;
  fwd_sel_t sel2;
  word_t    op_a;
  word_t    rs2_fwd;
  word_t    op_b;
  word_t    alu_result;

  forwarding_unit fwd0 (
    .id_rs1        (id_ex.rs1),
    .id_rs2        (id_ex.rs2),
    .mem_reg_write (ex_mem.ctrl.reg_write),
    .mem_rd        (ex_mem.rd),
    .wb            (wb),
    .sel1          (sel1),
    .sel2          (sel2)
  );

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t m_val, word_t w_val);
    case (sel)
      fwd_mem: return m_val;
      fwd_wb:  return w_val;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a    = fwd_mux(sel1, id_ex.rs1_val, mem_fwd, wb.value);
    rs2_fwd = fwd_mux(sel2, id_ex.rs2_val, mem_fwd, wb.value);
    op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;
  end

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_sub:  alu_result = op_a - op_b;
      alu_sll:  alu_result = op_a << op_b[4:0];
      alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  alu_result = op_a ^ op_b;
      alu_srl:  alu_result = op_a >> op_b[4:0];
      alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_result = op_a | op_b;
      alu_and:  alu_result = op_a & op_b;
      default:  alu_result = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else if (!stall) begin
      ex_mem <= '{ctrl: id_ex.ctrl, rd: id_ex.rd, rs2: id_ex.rs2,
                  alu_result: alu_result, store_val: rs2_fwd, imm: id_ex.imm};
    end
  end

endmodule

// File: forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
  import rv_pkg::*;
(
  input  reg_idx_t id_rs1,
  input  reg_idx_t id_rs2,
  input  logic     mem_reg_write,
  input  reg_idx_t mem_rd,
  input  wb_t      wb,
  output fwd_sel_t sel1,
  output fwd_sel_t sel2
);

  // Youngest producer wins and x0 never forwards
  function automatic fwd_sel_t pick(reg_idx_t rs, logic m_we, reg_idx_t m_rd, wb_t w);
    if (rs == '0) begin
      return fwd_reg;
    end else if (m_we && m_rd == rs) begin
      return fwd_mem;
    end else if (w.reg_write && w.rd == rs) begin
      return fwd_wb;
    end
    return fwd_reg;
  endfunction

  always_comb begin
    sel1 = pick(id_rs1, mem_reg_write, mem_rd, wb);
    sel2 = pick(id_rs2, mem_reg_write, mem_rd, wb);
  end

endmodule

// File: list.f
rv_pkg.sv
register_file.sv
decode_stage.sv
forwarding_unit.sv
execute_stage.sv
load_store_unit.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  ex_mem_t   ex_mem,
  input  word_t     dmem_rdata,
  input  logic      dmem_resp,
  output dmem_req_t dmem_req,
  output word_t     mem_fwd,
  output logic      stall,
  output wb_t       wb
);

  logic [1:0] offset;
  word_t      store_val;
  word_t      lane_data;
  word_t      load_val;

  assign offset = ex_mem.alu_result[1:0];

  // Late store data from the instruction just retiring
  assign store_val = (wb.reg_write && wb.rd == ex_mem.rs2 && ex_mem.rs2 != '0) ?
                     wb.value : ex_mem.store_val;

  always_comb begin
    dmem_req.addr  = {ex_mem.alu_result[xlen-1:2], 2'b00};
    dmem_req.read  = ex_mem.ctrl.mem_read;
    dmem_req.write = ex_mem.ctrl.mem_write;
    dmem_req.wdata = store_val << {offset, 3'b000};
    dmem_req.mbe   = 4'b0000;
    if (ex_mem.ctrl.mem_write) begin
      case (store_funct_t'(ex_mem.ctrl.funct3))
        sb:      dmem_req.mbe = 4'b0001 << offset;
        sh:      dmem_req.mbe = 4'b0011 << offset;
        default: dmem_req.mbe = 4'b1111;
      endcase
    end
  end

  // Freeze until the memory answers
  assign stall = (dmem_req.read || dmem_req.write) && !dmem_resp;

  // Addressed byte or halfword moved down to bit 0
  assign lane_data = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (load_funct_t'(ex_mem.ctrl.funct3))
      lb:      load_val = {{24{lane_data[7]}}, lane_data[7:0]};
      lbu:     load_val = {24'h000000, lane_data[7:0]};
      lh:      load_val = {{16{lane_data[15]}}, lane_data[15:0]};
      lhu:     load_val = {16'h0000, lane_data[15:0]};
      default: load_val = dmem_rdata;
    endcase
  end

  always_comb begin
    case (ex_mem.ctrl.result_sel)
      res_imm:  mem_fwd = ex_mem.imm;
      res_load: mem_fwd = load_val;
      default:  mem_fwd = ex_mem.alu_result;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else if (!stall) begin
      wb <= '{reg_write: ex_mem.ctrl.reg_write, rd: ex_mem.rd, value: mem_fwd};
    end
  end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  wb_t      wb,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_val,
  output word_t    rs2_val
);

  word_t regs [1:31];

  // x0 reads zero and a same-cycle write passes through
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb.reg_write && wb.rd == idx) begin
      return wb.value;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output word_t     imem_addr,
  input  word_t     imem_rdata,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  input  logic      dmem_resp
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_val;
  word_t    rs2_val;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  word_t    mem_fwd;
  wb_t      wb;
  logic     stall;

  decode_stage decode0 (
    .clk, .rst_n, .stall, .imem_rdata, .imem_addr,
    .rs1, .rs2, .rs1_val, .rs2_val, .id_ex
  );

  register_file rf0 (
    .clk, .rst_n, .wb, .rs1, .rs2, .rs1_val, .rs2_val
  );

  execute_stage execute0 (
    .clk, .rst_n, .stall, .id_ex, .mem_fwd, .wb, .ex_mem
  );

  load_store_unit lsu0 (
    .clk, .rst_n, .ex_mem, .dmem_rdata, .dmem_resp,
    .dmem_req, .mem_fwd, .stall, .wb
  );

endmodule

// File: rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions
  import rv_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input dmem_req_t dmem_req,
  input logic      dmem_resp
);

  int held_fails = 0;
  int exclusive_fails = 0;
  int mbe_fails = 0;

  // A pending request may not move until it is answered
  request_held: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_req.read || dmem_req.write) && !dmem_resp |=> $stable(dmem_req))
  else begin
    held_fails++;
    $error("data request changed while waiting for its response");
  end

  read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_req.read && dmem_req.write))
  else begin
    exclusive_fails++;
    $error("data request has read and write high together");
  end

  // Byte enables only on writes
  mbe_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_req.mbe != 4'b0000) == dmem_req.write)
  else begin
    mbe_fails++;
    $error("byte mask does not match the write flag");
  end

endmodule

bind rv_core rv_core_assertions assertions0 (.clk, .rst_n, .dmem_req, .dmem_resp);

// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // First fetch address after reset
  localparam word_t reset_pc = 32'h0000_0000;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } opcode_t;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_t;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct_t;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_mem,
    fwd_wb
  } fwd_sel_t;

  typedef enum logic [1:0] {
    res_alu,
    res_imm,
    res_load
  } result_sel_t;

  // All zero is a bubble
  typedef struct packed {
    alu_op_t     alu_op;
    logic        use_imm;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    result_sel_t result_sel;
    logic [2:0]  funct3;
  } ctrl_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    reg_idx_t rs2;
    word_t    alu_result;
    word_t    store_val;
    word_t    imm;
  } ex_mem_t;

  // Writeback bus and last forwarding source
  typedef struct packed {
    logic     reg_write;
    reg_idx_t rd;
    word_t    value;
  } wb_t;

  typedef struct packed {
    word_t      addr;
    logic       read;
    logic       write;
    word_t      wdata;
    logic [3:0] mbe;
  } dmem_req_t;

endpackage

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
;

  localparam word_t nop = 32'h0000_0013;
  localparam word_t load_base = 32'h100;
  localparam word_t store_base = 32'h180;
  localparam word_t result_base = 32'h200;
  localparam word_t sentinel = 32'h3fc;

  logic      clk;
  logic      rst_n;
  word_t     imem_addr;
  word_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      dmem_resp;

  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_val [$];
  int    slot;
  int    errors = 0;
  int    checks = 0;
  int    max_delay = 0;
  int    delay = 0;
  logic  busy = 1'b0;
  logic  sentinel_seen = 1'b0;
  logic  pc_armed = 1'b0;
  word_t exp_pc;

  rv_core dut0 (
    .clk, .rst_n, .imem_addr, .imem_rdata, .dmem_req, .dmem_rdata, .dmem_resp
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(string name, word_t actual, word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, actual, expected);
    end
  endtask

  // Memory models and fetch address tracking on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      dmem_resp = 1'b0;
      busy = 1'b0;
      pc_armed = 1'b0;
    end else begin
      if (pc_armed) begin
        check("imem_addr", imem_addr, exp_pc);
      end
      if (dmem_resp) begin
        dmem_resp = 1'b0;
        busy = 1'b0;
      end
      if (dmem_req.read || dmem_req.write) begin
        if (!busy) begin
          busy = 1'b1;
          delay = $urandom % (max_delay + 1);
        end
        if (delay == 0) begin
          for (int b = 0; b < 4; b++) begin
            if (dmem_req.write && dmem_req.mbe[b]) begin
              dmem[dmem_req.addr[9:2]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
            end
          end
          if (dmem_req.write && dmem_req.addr == sentinel) begin
            sentinel_seen = 1'b1;
          end
          dmem_rdata = dmem[dmem_req.addr[9:2]];
          dmem_resp = 1'b1;
        end else begin
          delay--;
        end
      end
      // PC holds only while a request waits
      exp_pc = ((dmem_req.read || dmem_req.write) && !dmem_resp) ? imem_addr
                                                                  : imem_addr + 32'd4;
      pc_armed = 1'b1;
    end
    imem_rdata = imem[imem_addr[9:2]];
  end

  function automatic word_t r_instr(logic alt, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_instr(opcode_t op, logic [11:0] imm, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Base register is always x0 here
  function automatic word_t s_instr(logic [2:0] f3, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t lui_instr(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op_lui};
  endfunction

  function automatic word_t fill_word(int idx);
    return 32'h9e37_79b9 * word_t'(idx + 1);
  endfunction

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return word_t'($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t merge_store(word_t old, word_t data, int off, int bytes);
    word_t res;
    res = old;
    for (int b = 0; b < bytes; b++) begin
      res[8*(off+b) +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic word_t load_ref(word_t w, int off, int bytes, logic uns);
    word_t v;
    v = w >> (8 * off);
    if (bytes == 1) begin
      return uns ? {24'h000000, v[7:0]} : {{24{v[7]}}, v[7:0]};
    end else if (bytes == 2) begin
      return uns ? {16'h0000, v[15:0]} : {{16{v[15]}}, v[15:0]};
    end
    return w;
  endfunction

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    slot = 0;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i);
    end
  endtask

  task automatic expect_word(word_t addr, word_t value);
    exp_addr.push_back(addr);
    exp_val.push_back(value);
  endtask

  task automatic load_const(reg_idx_t rd, word_t value);
    word_t upper;
    upper = value + 32'h800;
    prog.push_back(lui_instr(rd, upper[31:12]));
    prog.push_back(i_instr(op_imm, value[11:0], rd, 3'b000, rd));
  endtask

  task automatic save_result(reg_idx_t rs, word_t value);
    word_t addr;
    addr = result_base + word_t'(slot * 4);
    prog.push_back(s_instr(sw, rs, addr[11:0]));
    expect_word(addr, value);
    slot++;
  endtask

  task automatic reset_core();
    @(negedge clk);
    rst_n <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check("imem_addr", imem_addr, reset_pc);
      check("dmem_req read/write", word_t'({dmem_req.read, dmem_req.write}), '0);
    end
    rst_n <= 1'b1;
    #1;
    check("imem_addr after reset", imem_addr, reset_pc);
    check("dmem_req read/write after reset", word_t'({dmem_req.read, dmem_req.write}), '0);
  endtask

  task automatic run_program(string name);
    int cyc;
    prog.push_back(s_instr(sw, 5'd0, sentinel[11:0]));
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : nop;
    end
    sentinel_seen = 1'b0;
    reset_core();
    cyc = 0;
    while (!sentinel_seen && cyc < 2000) begin
      @(negedge clk);
      cyc++;
    end
    if (!sentinel_seen) begin
      errors++;
      $display("%s: sentinel store did not arrive within %0d cycles", name, cyc);
    end
    foreach (exp_addr[i]) begin
      check($sformatf("%s dmem[%h]", name, exp_addr[i]), dmem[exp_addr[i][9:2]], exp_val[i]);
    end
  endtask

  task automatic alu_chains();
    localparam logic [29:0] r_f3s = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  r_alts = 10'b0010000010;
    localparam logic [26:0] i_f3s = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
    word_t acc;
    word_t bval;
    word_t rnd;
    logic [11:0] imm;
    logic [2:0] f3;
    logic alt;
    new_program();
    acc = $urandom;
    bval = $urandom;
    load_const(5'd1, acc);
    load_const(5'd2, bval);
    // Odd steps feed the chained value in as rs2
    for (int k = 0; k < 10; k++) begin
      f3 = r_f3s[3*k +: 3];
      alt = r_alts[k];
      if (k % 2 == 0) begin
        prog.push_back(r_instr(alt, 5'd2, 5'd1, f3, 5'd1));
        acc = alu_ref(f3, alt, acc, bval);
      end else begin
        prog.push_back(r_instr(alt, 5'd1, 5'd2, f3, 5'd1));
        acc = alu_ref(f3, alt, bval, acc);
      end
      save_result(5'd1, acc);
    end
    acc = $urandom;
    load_const(5'd3, acc);
    // Back to back immediates saved every other step
    for (int k = 0; k < 9; k++) begin
      f3 = i_f3s[3*k +: 3];
      alt = (k == 8);
      rnd = $urandom;
      imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b00000, rnd[4:0]} : rnd[11:0];
      prog.push_back(i_instr(op_imm, imm, 5'd3, f3, 5'd3));
      acc = alu_ref(f3, alt, acc, {{20{imm[11]}}, imm});
      if (k % 2 == 1 || k == 8) begin
        save_result(5'd3, acc);
      end
    end
    run_program("alu_chains");
  endtask

  task automatic lui_and_x0();
    word_t rnd;
    new_program();
    rnd = $urandom;
    prog.push_back(lui_instr(5'd5, rnd[19:0]));
    save_result(5'd5, {rnd[19:0], 12'h000});
    prog.push_back(i_instr(op_imm, 12'h05a, 5'd0, 3'b000, 5'd0));
    prog.push_back(lui_instr(5'd0, rnd[31:12]));
    prog.push_back(r_instr(1'b0, 5'd5, 5'd0, 3'b000, 5'd6));
    save_result(5'd0, '0);
    save_result(5'd6, {rnd[19:0], 12'h000});
    run_program("lui_and_x0");
  endtask

  task automatic store_lanes();
    word_t v;
    word_t addr;
    new_program();
    v = $urandom;
    load_const(5'd7, v);
    for (int off = 0; off < 4; off++) begin
      addr = store_base + word_t'(4 * off);
      prog.push_back(s_instr(sb, 5'd7, addr[11:0] + 12'(off)));
      expect_word(addr, merge_store(fill_word(int'(addr[9:2])), v, off, 1));
    end
    for (int h = 0; h < 2; h++) begin
      addr = store_base + 32'h10 + word_t'(4 * h);
      prog.push_back(s_instr(sh, 5'd7, addr[11:0] + 12'(2 * h)));
      expect_word(addr, merge_store(fill_word(int'(addr[9:2])), v, 2 * h, 2));
    end
    // Store data produced by the previous instruction
    prog.push_back(i_instr(op_imm, 12'h001, 5'd7, 3'b000, 5'd8));
    save_result(5'd8, v + 32'd1);
    run_program("store_lanes");
  endtask

  task automatic load_extension();
    word_t w;
    word_t word;
    word_t addr;
    new_program();
    w = $urandom;
    dmem[load_base[9:2]] = w;
    dmem[load_base[9:2] + 8'd1] = ~w;
    for (int wi = 0; wi < 2; wi++) begin
      word = (wi == 0) ? w : ~w;
      addr = load_base + word_t'(4 * wi);
      for (int off = 0; off < 4; off++) begin
        prog.push_back(i_instr(op_load, addr[11:0] + 12'(off), 5'd0, lb, 5'd10));
        save_result(5'd10, load_ref(word, off, 1, 1'b0));
        prog.push_back(i_instr(op_load, addr[11:0] + 12'(off), 5'd0, lbu, 5'd10));
        save_result(5'd10, load_ref(word, off, 1, 1'b1));
      end
      for (int off = 0; off < 4; off += 2) begin
        prog.push_back(i_instr(op_load, addr[11:0] + 12'(off), 5'd0, lh, 5'd11));
        save_result(5'd11, load_ref(word, off, 2, 1'b0));
        prog.push_back(i_instr(op_load, addr[11:0] + 12'(off), 5'd0, lhu, 5'd11));
        save_result(5'd11, load_ref(word, off, 2, 1'b1));
      end
      prog.push_back(i_instr(op_load, addr[11:0], 5'd0, lw, 5'd12));
      save_result(5'd12, word);
    end
    // Loaded value used by the very next instruction
    prog.push_back(i_instr(op_load, load_base[11:0], 5'd0, lw, 5'd12));
    prog.push_back(i_instr(op_imm, 12'h003, 5'd12, 3'b000, 5'd13));
    save_result(5'd13, w + 32'd3);
    run_program("load_extension");
  endtask

  initial begin
    void'($urandom(32'h8f9e_b539));
    rst_n = 1'b0;
    imem_rdata = nop;
    dmem_rdata = '0;
    dmem_resp = 1'b0;
    // First pass answers at once and the second with random latency
    for (int pass = 0; pass < 2; pass++) begin
      max_delay = pass * 3;
      alu_chains();
      lui_and_x0();
      store_lanes();
      load_extension();
    end
    errors += dut0.assertions0.held_fails + dut0.assertions0.exclusive_fails +
              dut0.assertions0.mbe_fails;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
